// File: files.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_exec_unit.sv
rv_lsu.sv
rv_core.sv
rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing -f files.f --top-module rv_core_tb -o rv_core_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
exit 0

// File: rv_core.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,
  output dmem_wr_t    dmem_wr,
  output logic        ebreak
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;

  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] rd_data;

  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] target;
  logic                take_branch;
  logic [`RV_XLEN-1:0] load_data;

  // --------------------
  // Fetch
  // --------------------

  assign pc_plus4 = pc + 32'd4;

  // One instruction per edge, no stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= take_branch ? target : pc_plus4;
    end
  end

  // SRAM-style fetch, data back same cycle
  assign imem_raddr = pc;

  // --------------------
  // Decode and operands
  // --------------------

  rv_decoder decoder_i (
    .instr(imem_rdata),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd_en   (ctrl.reg_write),
    .rd      (ctrl.rd),
    .rd_data (rd_data)
  );

  // --------------------
  // Execute and memory
  // --------------------

  rv_exec_unit exec_i (
    .ctrl       (ctrl),
    .pc         (pc),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .target     (target),
    .take_branch(take_branch)
  );

  // ALU sum doubles as the data address
  rv_lsu lsu_i (
    .ctrl      (ctrl),
    .rst_n     (rst_n),
    .addr      (alu_result),
    .store_data(rs2_data),
    .dmem_rdata(dmem_rdata),
    .dmem_raddr(dmem_raddr),
    .dmem_wr   (dmem_wr),
    .load_data (load_data)
  );

  // --------------------
  // Writeback
  // --------------------

  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = load_data;
      // Link address for JAL/JALR
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  // Halt indicator, quiet during reset
  assign ebreak = rst_n & ctrl.is_ebreak;

endmodule

// File: rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// --------------------
// Reference state
// --------------------

logic [31:0] model_pc;
logic [31:0] model_regs [0:`RV_NREGS-1];
logic [31:0] model_dmem [0:`RV_DMEM_WORDS-1];

// Expected outputs for the instruction at model_pc
logic        model_st_we;
logic [31:0] model_st_addr;
logic [31:0] model_st_data;
logic [3:0]  model_st_strb;
logic        model_ld;
logic [31:0] model_ld_addr;
logic        model_ebreak;

// Integer ops, alt selects SUB or SRA
function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
  case (f3)
    3'b000:  return alt ? x - y : x + y;
    3'b001:  return x << y[4:0];
    3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'b011:  return (x < y) ? 32'd1 : 32'd0;
    3'b100:  return x ^ y;
    3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
    3'b110:  return x | y;
    default: return x & y;
  endcase
endfunction

task automatic reset_model();
  model_pc = `RV_RESET_PC;
  for (int i = 0; i < `RV_NREGS; i++) begin
    model_regs[i] = 32'd0;
  end
  // Same image the testbench memory starts with
  for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
    model_dmem[i] = fill_word(i);
  end
endtask

// Execute one instruction
task automatic step_model();
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] ea;
  logic [31:0] word;
  logic [31:0] res;
  logic [31:0] next_pc;
  logic [2:0]  f3;
  logic        wr;
  logic        taken;
  ins          = imem[model_pc[9:2]];
  f3           = ins[14:12];
  a            = model_regs[ins[19:15]];
  b            = model_regs[ins[24:20]];
  imm_i        = {{20{ins[31]}}, ins[31:20]};
  next_pc      = model_pc + 32'd4;
  res          = 32'd0;
  wr           = 1'b0;
  taken        = 1'b0;
  model_st_we  = 1'b0;
  model_ld     = 1'b0;
  model_ebreak = 1'b0;
  case (ins[6:0])
    7'b0110011: begin
      wr  = 1'b1;
      res = alu_calc(f3, ins[30], a, b);
    end
    7'b0010011: begin
      // Only the shift right form has an alternate
      wr  = 1'b1;
      res = alu_calc(f3, ins[30] && f3 == 3'b101, a, imm_i);
    end
    7'b0000011: begin
      ea            = a + imm_i;
      model_ld      = 1'b1;
      model_ld_addr = ea;
      word          = model_dmem[ea[9:2]] >> (ea[1:0] * 8);
      wr            = 1'b1;
      case (f3)
        3'b000:  res = {{24{word[7]}}, word[7:0]};
        3'b001:  res = {{16{word[15]}}, word[15:0]};
        3'b100:  res = {24'd0, word[7:0]};
        3'b101:  res = {16'd0, word[15:0]};
        default: res = word;
      endcase
    end
    7'b0100011: begin
      ea            = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      model_st_we   = 1'b1;
      model_st_addr = ea;
      // Narrow data repeated on every lane
      model_st_data = (f3[1:0] == 2'b00) ? {4{b[7:0]}} :
                      (f3[1:0] == 2'b01) ? {2{b[15:0]}} : b;
      for (int k = 0; k < 4; k++) begin
        // Lane inside the addressed unit
        model_st_strb[k] = (f3[1:0] == 2'b10) ||
                           (f3[1:0] == 2'b01 && k[1] == ea[1]) ||
                           (f3[1:0] == 2'b00 && k[1:0] == ea[1:0]);
        if (model_st_strb[k]) begin
          model_dmem[ea[9:2]][8*k +: 8] = model_st_data[8*k +: 8];
        end
      end
    end
    7'b1100011: begin
      case (f3)
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        3'b101:  taken = ($signed(a) >= $signed(b));
        3'b110:  taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) begin
        next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
    end
    7'b1101111: begin
      wr      = 1'b1;
      res     = model_pc + 32'd4;
      next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    7'b1100111: begin
      // Target taken before rd is written
      wr      = 1'b1;
      res     = model_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    7'b0110111: begin
      wr  = 1'b1;
      res = {ins[31:12], 12'd0};
    end
    7'b0010111: begin
      wr  = 1'b1;
      res = model_pc + {ins[31:12], 12'd0};
    end
    7'b1110011: begin
      model_ebreak = (ins == 32'h0010_0073);
    end
    default: begin
    end
  endcase
  // x0 stays zero
  if (wr && ins[11:7] != 5'd0) begin
    model_regs[ins[11:7]] = res;
  end
  model_pc = next_pc;
endtask

`endif

// File: rv_core_tb.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int RESET_CYCLES = 5;
  localparam int RAND_CYCLES  = 2000;
  localparam int DIR_WORDS    = 8;
  // Words LOOP_WORD up to the last one jump back into the random block
  localparam int LOOP_WORD    = 248;
  // Run length plus a drain through the whole memory
  localparam int TIMEOUT_NS   =
    (RESET_CYCLES + RAND_CYCLES + DIR_WORDS + `RV_IMEM_WORDS + 20) * 4;
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // Writes to x0, then x0 stored as word, half and byte
  localparam logic [31:0] DIRECTED [DIR_WORDS] = '{
    32'h1230_0013,  // addi x0, x0, 0x123
    32'hABCD_E037,  // lui  x0, 0xabcde
    32'hFFF0_0293,  // addi x5, x0, -1
    32'h0052_8033,  // add  x0, x5, x5
    32'h1000_2023,  // sw   x0, 256(x0)
    32'h1000_1123,  // sh   x0, 258(x0)
    32'h1000_01A3,  // sb   x0, 259(x0)
    32'h1000_2303   // lw   x6, 256(x0)
  };

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  dmem_wr_t    dmem_wr;
  logic        ebreak;

  logic [31:0] imem [0:`RV_IMEM_WORDS-1];
  logic [31:0] dmem [0:`RV_DMEM_WORDS-1];
  integer      seed;

  // Initial data image, every address bit matters
  function automatic logic [31:0] fill_word(input int i);
    return (32'h9E37_79B9 * (i + 1)) ^ 32'h0F0F_3C3C;
  endfunction

  `include "rv_core_model.svh"

  rv_core rv_core_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_wr   (dmem_wr),
    .ebreak    (ebreak)
  );

  // SRAM-style memories answer in the same cycle
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Data memory with byte strobes, written at the rising edge
  initial begin
    for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
      dmem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      if (dmem_wr.we) begin
        for (int k = 0; k < 4; k++) begin
          if (dmem_wr.wstrb[k]) begin
            dmem[dmem_wr.addr[9:2]][8*k +: 8] = dmem_wr.data[8*k +: 8];
          end
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the core did not reach EBREAK in time");
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // --------------------
  // Program generator
  // --------------------

  // One instruction of a kept class, x0-based memory and JALR addresses
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [31:0] v;
    logic [31:0] boff;
    logic [9:0]  addr;
    logic [2:0]  f3;
    int          off;
    int          cls;
    r    = $random(seed);
    v    = $random(seed);
    f3   = r[17:15];
    cls  = int'(r[31:20] % 12'd9);
    // Offset of -7..-1 or 1..7 words
    off  = int'(v[31:28] % 4'd14) - 7;
    if (off >= 0) begin
      off = off + 1;
    end
    boff = off * 4;
    case (cls)
      0: return {1'b0, r[18] & (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                 r[14:10], r[9:5], f3, r[4:0], 7'b0110011};
      1: begin
        // Shift immediates keep a legal funct7
        if (f3 == 3'b001) v[11:5] = 7'b0;
        if (f3 == 3'b101) v[11:5] = {1'b0, r[18], 5'b0};
        return {v[11:0], r[9:5], f3, r[4:0], 7'b0010011};
      end
      2: begin
        f3 = v[14:12] % 3'd5;
        if (f3 > 3'd2) f3 = f3 + 3'd1;
        addr = v[9:0] & ~((10'd1 << f3[1:0]) - 10'd1);
        return {2'b0, addr, 5'd0, f3, r[4:0], 7'b0000011};
      end
      3: begin
        f3   = v[14:12] % 3'd3;
        addr = v[9:0] & ~((10'd1 << f3[1:0]) - 10'd1);
        return {2'b0, addr[9:5], r[14:10], 5'd0, f3, addr[4:0], 7'b0100011};
      end
      4: begin
        f3 = v[14:12] % 3'd6;
        if (f3 > 3'd1) f3 = f3 + 3'd2;
        return {boff[12], boff[10:5], r[14:10], r[9:5], f3, boff[4:1], boff[11], 7'b1100011};
      end
      5: return {boff[20], boff[10:1], boff[11], boff[19:12], r[4:0], 7'b1101111};
      6: begin
        // Absolute target somewhere in the random block, bit 0 set at random
        boff    = (DIR_WORDS + int'(v[7:0] % 8'd240)) * 4;
        boff[0] = v[8];
        return {boff[11:0], 5'd0, 3'b000, r[4:0], 7'b1100111};
      end
      7: return {v[31:12], r[4:0], 7'b0110111};
      default: return {v[31:12], r[4:0], 7'b0010111};
    endcase
  endfunction

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    logic [31:0] boff;
    int          cycle;
    logic        done;
    rst_n = 1'b0;
    seed  = 62083;
    for (int w = 0; w < `RV_IMEM_WORDS; w++) begin
      if (w < DIR_WORDS) begin
        imem[w] = DIRECTED[w];
      end else if (w < LOOP_WORD) begin
        imem[w] = random_instr();
      end else if (w < `RV_IMEM_WORDS - 1) begin
        boff    = (DIR_WORDS - w) * 4;
        imem[w] = {boff[20], boff[10:1], boff[11], boff[19:12], 5'd0, 7'b1101111};
      end else begin
        imem[w] = EBREAK_WORD;
      end
    end
    // Store at the reset PC, its request has to stay off in reset
    imem[0] = DIRECTED[4];

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    compare_value("imem_raddr", imem_raddr, `RV_RESET_PC);
    compare_value("dmem_wr.we", {31'd0, dmem_wr.we}, 32'd0);
    imem[0] = DIRECTED[0];
    rst_n = 1'b1;
    reset_model();

    cycle = 0;
    done  = 1'b0;
    while (!done) begin
      // NOPs everywhere so the run drains into EBREAK
      if (cycle == RAND_CYCLES) begin
        for (int w = 0; w < `RV_IMEM_WORDS - 1; w++) begin
          imem[w] = NOP_WORD;
        end
      end
      #1;
      compare_value("imem_raddr", imem_raddr, model_pc);
      step_model();
      compare_value("dmem_wr.we", {31'd0, dmem_wr.we}, {31'd0, model_st_we});
      if (model_st_we) begin
        compare_value("dmem_wr.addr", dmem_wr.addr, model_st_addr);
        compare_value("dmem_wr.data", dmem_wr.data, model_st_data);
        compare_value("dmem_wr.wstrb", {28'd0, dmem_wr.wstrb}, {28'd0, model_st_strb});
        // Stored x0 is zero whatever was written to it
        if (imem_rdata[24:20] == 5'd0) begin
          compare_value("dmem_wr.data", dmem_wr.data, 32'd0);
        end
      end
      if (model_ld) begin
        compare_value("dmem_raddr", dmem_raddr, model_ld_addr);
      end
      compare_value("ebreak", {31'd0, ebreak}, {31'd0, model_ebreak});
      done  = model_ebreak;
      cycle = cycle + 1;
      if (!done) begin
        @(negedge clk);
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: rv_decoder.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
  input  logic [31:0]         instr,
  output ctrl_t               ctrl,
  output logic [`RV_XLEN-1:0] imm
);

  // EBREAK is one fixed encoding
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  opcode_e opcode;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode = opcode_e'(instr[6:0]);

  // --------------------
  // Immediate formats
  // --------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  // Branch offsets are in halfwords, bit 0 always zero
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------
  // Control decode
  // --------------------

  always_comb begin
    alu_op_e arith_op;

    // funct3 to ALU op for OP and OP_IMM
    case (instr[14:12])
      // SUB only for register form, ADDI ignores instr[30]
      3'b000:  arith_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      // SRA/SRAI share funct7 bit 5
      3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase

    // Defaults describe a no-op
    ctrl          = '0;
    ctrl.a_src    = A_RS1;
    ctrl.alu_op   = ALU_ADD;
    ctrl.res_src  = RES_ALU;
    ctrl.funct3   = instr[14:12];
    ctrl.rd       = instr[11:7];
    ctrl.rs1      = instr[19:15];
    ctrl.rs2      = instr[24:20];
    imm           = imm_i;

    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.res_src   = RES_MEM;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_s;
      end
      OPC_BRANCH: begin
        // Compare happens outside the ALU
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_src   = RES_PC4;
        imm            = imm_j;
      end
      OPC_JALR: begin
        // ALU forms rs1 + imm for the target
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.res_src   = RES_PC4;
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src     = A_ZERO;
        ctrl.b_is_imm  = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src     = A_PC;
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_u;
      end
      OPC_SYSTEM: begin
        // ECALL and CSR ops fall through as no-ops
        ctrl.is_ebreak = (instr == EBREAK_INSTR);
      end
      OPC_MISC_MEM: begin
        // FENCE, nothing to order in this core
        ctrl.reg_write = 1'b0;
      end
      default: begin
        // Unknown opcode, no side effects
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// File: rv_exec_unit.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_exec_unit import rv_pkg::*; (
  input  ctrl_t               ctrl,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] target,
  output logic                take_branch
);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [4:0]          shamt;
  logic                cmp_true;

  // --------------------
  // Operand select
  // --------------------

  always_comb begin
    case (ctrl.a_src)
      A_PC:    alu_a = pc;
      A_ZERO:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = ctrl.b_is_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  // --------------------
  // ALU
  // --------------------

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_SLL:    alu_result = alu_a << shamt;
      ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SRL:    alu_result = alu_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:    alu_result = $unsigned($signed(alu_a) >>> shamt);
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = alu_a + alu_b;
    endcase
  end

  // --------------------
  // Branch compare
  // --------------------

  // Always on the raw registers, never the B mux
  always_comb begin
    case (ctrl.funct3)
      3'b000:  cmp_true = (rs1_data == rs2_data);
      3'b001:  cmp_true = (rs1_data != rs2_data);
      3'b100:  cmp_true = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  cmp_true = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  cmp_true = (rs1_data < rs2_data);
      3'b111:  cmp_true = (rs1_data >= rs2_data);
      default: cmp_true = 1'b0;
    endcase
  end

  // Jumps always redirect
  assign take_branch = ctrl.is_jump | (ctrl.is_branch & cmp_true);

  // JALR uses the ALU sum with bit 0 dropped, others PC-relative
  assign target = ctrl.is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc + imm;

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_lsu import rv_pkg::*; (
  input  ctrl_t               ctrl,
  input  logic                rst_n,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] store_data,
  input  logic [31:0]         dmem_rdata,
  output logic [31:0]         dmem_raddr,
  output dmem_wr_t            dmem_wr,
  output logic [`RV_XLEN-1:0] load_data
);

  logic [31:0] rdata_shifted;

  // --------------------
  // Store path
  // --------------------

  // Request held off while in reset
  assign dmem_wr.we   = ctrl.mem_write & rst_n;
  assign dmem_wr.addr = addr;

  // Lane replicate, strobes pick the bytes
  always_comb begin
    case (ctrl.funct3[1:0])
      2'b00: begin
        dmem_wr.data  = {4{store_data[7:0]}};
        dmem_wr.wstrb = 4'b0001 << addr[1:0];
      end
      2'b01: begin
        dmem_wr.data  = {2{store_data[15:0]}};
        dmem_wr.wstrb = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wr.data  = store_data;
        dmem_wr.wstrb = 4'b1111;
      end
    endcase
  end

  // --------------------
  // Load path
  // --------------------

  // Address parked at zero when not loading
  assign dmem_raddr = ctrl.mem_read ? addr : 32'd0;

  // Bring addressed byte/half down to bit 0
  assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      3'b001:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      3'b100:  load_data = {24'b0, rdata_shifted[7:0]};
      3'b101:  load_data = {16'b0, rdata_shifted[15:0]};
      // LW and reserved widths take the whole word
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

// File: rv_pkg.sv
package rv_pkg;

  // --------------------
  // Encodings
  // --------------------

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP       = 7'b0110011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_SYSTEM   = 7'b1110011,
    OPC_MISC_MEM = 7'b0001111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  // ALU A operand source
  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } a_src_e;

  // --------------------
  // Bundles
  // --------------------

  // Decoded control, one instruction
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_branch;
    logic     is_jump;
    logic     is_jalr;
    logic     is_ebreak;
    a_src_e   a_src;
    logic     b_is_imm;
    alu_op_e  alu_op;
    res_src_e res_src;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } ctrl_t;

  // Data memory write request
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  wstrb;
  } dmem_wr_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                rd_en,
  input  logic [4:0]          rd,
  input  logic [`RV_XLEN-1:0] rd_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  // Write port, lands on the next edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd != 5'd0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Read ports, x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Core data width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Testbench memory depths in words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif
